// ==== core.f ====
verilog/core_pkg.sv
verilog/stage_reg.sv
verilog/reg_file.sv
verilog/reg_file_bypass.sv
verilog/pipeline_control.sv
verilog/inst_fetch.sv
verilog/inst_decode.sv
verilog/execute.sv
verilog/mem_writeback.sv
verilog/core.sv
verif/core_tb_props.sv
verif/core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module core_tb -f core.f -o core_sim

./obj_dir/core_sim > sim.log 2>&1
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "no pass line in sim.log"
    exit 1
fi
exit 0

// ==== verif/core_tb.sv ====
`timescale 1ns/100ps

module core_tb;

    localparam core_pkg::addr_t reset_pc = 32'h1c00_0000;
    localparam int body_start = 19;
    localparam int marker_idx = 64;
    localparam int prog_len = 66;

    logic                clock = 1'b0;
    logic                reset;
    core_pkg::sram_req_t iram_req;
    core_pkg::data_t     iram_rd_data;
    core_pkg::sram_req_t dram_req;
    core_pkg::data_t     dram_rd_data;
    core_pkg::wb_trace_t trace;

    core_pkg::data_t     imem [256];
    core_pkg::data_t     dmem [64];
    core_pkg::data_t     ref_dmem [64];
    core_pkg::data_t     ref_regs [32];
    core_pkg::wb_trace_t exp_q [$];
    logic [31:0]         lfsr;
    int                  n_expected = -1;
    int                  retired = 0;
    int                  value_errors = 0;
    int                  other_errors = 0;
    logic                first_seen = 1'b0;

    core #(.reset_pc(reset_pc)) dut_i (
        .clock(clock), .reset(reset),
        .iram_req(iram_req), .iram_rd_data(iram_rd_data),
        .dram_req(dram_req), .dram_rd_data(dram_rd_data),
        .trace(trace)
    );

    always #10 clock = ~clock;

    // only the byte lanes set in the mask change
    function automatic core_pkg::data_t merge_bytes(input core_pkg::data_t old_word,
                                                    input core_pkg::data_t new_word,
                                                    input logic [3:0] mask);
        core_pkg::data_t word;
        word = old_word;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                word[8 * b +: 8] = new_word[8 * b +: 8];
            end
        end
        return word;
    endfunction

    // both memories answer one cycle after the request
    always @(posedge clock) begin
        if (iram_req.rd_en) begin
            iram_rd_data <= imem[8'((iram_req.addr - reset_pc) >> 2)];
        end
        if (dram_req.wr_en) begin
            dmem[dram_req.addr[7:2]] <= merge_bytes(dmem[dram_req.addr[7:2]],
                                                    dram_req.wr_data, dram_req.wr_mask);
        end
        if (dram_req.rd_en) begin
            dram_rd_data <= dmem[dram_req.addr[7:2]];
        end
    end

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) begin
                lfsr = lfsr ^ 32'ha300_0000;
            end
            r = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic core_pkg::data_t enc_3r(input logic [16:0] op, input int rd,
                                                input int rj, input int rk);
        return {op, 5'(rk), 5'(rj), 5'(rd)};
    endfunction

    function automatic core_pkg::data_t enc_ri12(input logic [9:0] op, input int rd,
                                                  input int rj, input logic [11:0] imm);
        return {op, imm, 5'(rj), 5'(rd)};
    endfunction

    function automatic core_pkg::data_t enc_br(input logic [5:0] op, input int rj,
                                                input int rd, input logic [25:0] offs);
        if (op == core_pkg::op_b) begin
            return {op, offs[15:0], offs[25:16]};
        end
        return {op, offs[15:0], 5'(rj), 5'(rd)};
    endfunction

    task automatic build_program();
        int           off;
        logic [2:0]   kind;
        logic [16:0]  ops [5];
        ops = '{core_pkg::op_add_w, core_pkg::op_sub_w, core_pkg::op_and,
                core_pkg::op_or, core_pkg::op_xor};
        // unused words write r31 and show up in the trace if executed
        foreach (imem[i]) begin
            imem[i] = enc_ri12(core_pkg::op_addi_w, 31, 0, 12'(i));
        end
        // forwarding chain, load-use, r0 writes, branches
        imem[0] = enc_ri12(core_pkg::op_addi_w, 1, 0, 12'd5);
        imem[1] = enc_ri12(core_pkg::op_addi_w, 2, 1, 12'd3);
        imem[2] = enc_3r(core_pkg::op_add_w, 3, 2, 1);
        imem[3] = enc_3r(core_pkg::op_sub_w, 4, 3, 1);
        imem[4] = enc_ri12(core_pkg::op_st_w, 4, 0, 12'd8);
        imem[5] = enc_ri12(core_pkg::op_ld_w, 5, 0, 12'd8);
        imem[6] = enc_3r(core_pkg::op_add_w, 6, 5, 5);
        imem[7] = enc_ri12(core_pkg::op_addi_w, 0, 6, 12'd1);
        imem[8] = enc_3r(core_pkg::op_add_w, 7, 0, 6);
        imem[9] = enc_br(core_pkg::op_beq, 5, 4, 26'd2);
        imem[10] = enc_ri12(core_pkg::op_addi_w, 7, 0, 12'd99);
        imem[11] = enc_br(core_pkg::op_bne, 5, 4, 26'd2);
        imem[12] = {7'h0a, 20'h12345, 5'd8};
        imem[13] = enc_br(core_pkg::op_b, 0, 0, 26'd2);
        imem[14] = enc_ri12(core_pkg::op_addi_w, 8, 0, 12'd1);
        imem[15] = enc_3r(core_pkg::op_xor, 9, 8, 3);
        imem[16] = enc_br(core_pkg::op_beq, 9, 3, 26'd2);
        imem[17] = enc_br(core_pkg::op_bne, 9, 3, 26'd2);
        imem[18] = enc_ri12(core_pkg::op_addi_w, 10, 0, 12'd77);
        for (int i = body_start; i < marker_idx; i++) begin
            kind = take_bits(3);
            off = 1 + take_bits(2);
            if (i + off > marker_idx) begin
                off = marker_idx - i;
            end
            case (kind)
                0, 1: imem[i] = enc_3r(ops[take_bits(3) % 5], take_bits(3), take_bits(3),
                                       take_bits(3));
                2: imem[i] = enc_ri12(core_pkg::op_addi_w, take_bits(3), take_bits(3),
                                      take_bits(12));
                3: imem[i] = {7'h0a, 20'(take_bits(20)), 5'(take_bits(3))};
                4: imem[i] = enc_ri12(core_pkg::op_ld_w, take_bits(3), 0,
                                      {6'(take_bits(6)), 2'b00});
                5: imem[i] = enc_ri12(core_pkg::op_st_w, take_bits(3), 0,
                                      {6'(take_bits(6)), 2'b00});
                6: imem[i] = enc_br(take_bits(1) ? core_pkg::op_bne : core_pkg::op_beq,
                                    take_bits(3), take_bits(3), 26'(off));
                default: imem[i] = enc_br(core_pkg::op_b, 0, 0, 26'(off));
            endcase
        end
        // last register write, then spin
        imem[marker_idx] = enc_ri12(core_pkg::op_addi_w, 30, 0, 12'h5a5);
        imem[marker_idx + 1] = enc_br(core_pkg::op_b, 0, 0, 26'd0);
    endtask

    // instruction-set model stepping one instruction at a time
    function automatic void run_reference();
        int              i;
        core_pkg::data_t inst;
        core_pkg::data_t vj;
        core_pkg::data_t vk;
        core_pkg::data_t vd;
        core_pkg::data_t res;
        core_pkg::data_t si12;
        logic            wr;
        int              rd;
        i = 0;
        foreach (ref_regs[r]) begin
            ref_regs[r] = '0;
        end
        for (int step = 0; step < 4 * prog_len; step++) begin
            inst = imem[i];
            rd = inst[4:0];
            vd = ref_regs[rd];
            vj = ref_regs[inst[9:5]];
            vk = ref_regs[inst[14:10]];
            si12 = {{20{inst[21]}}, inst[21:10]};
            wr = 1'b1;
            res = '0;
            if (inst[31:26] == 6'h14) begin
                if ({inst[9:0], inst[25:10]} == '0) begin
                    break;
                end
                i += int'(signed'({inst[9:0], inst[25:10]}));
                continue;
            end
            if (inst[31:26] == 6'h16 || inst[31:26] == 6'h17) begin
                if ((vj == vd) == (inst[31:26] == 6'h16)) begin
                    i += int'(signed'(inst[25:10]));
                end else begin
                    i++;
                end
                continue;
            end
            case (inst[31:15])
                17'h00020: res = vj + vk;
                17'h00022: res = vj - vk;
                17'h00029: res = vj & vk;
                17'h0002a: res = vj | vk;
                17'h0002b: res = vj ^ vk;
                default: begin
                    if (inst[31:25] == 7'h0a) begin
                        res = {inst[24:5], 12'b0};
                    end else if (inst[31:22] == 10'h00a) begin
                        res = vj + si12;
                    end else if (inst[31:22] == 10'h0a2) begin
                        res = ref_dmem[(vj + si12) >> 2];
                    end else if (inst[31:22] == 10'h0a6) begin
                        ref_dmem[(vj + si12) >> 2] = vd;
                        wr = 1'b0;
                    end else begin
                        wr = 1'b0;
                    end
                end
            endcase
            if (wr && rd != 0) begin
                ref_regs[rd] = res;
                exp_q.push_back('{pc: reset_pc + 32'(i * 4), rd: 5'(rd), data: res,
                                  wr_en: 1'b1});
            end
            i++;
        end
    endfunction

    task automatic compare_trace(input string name, input core_pkg::wb_trace_t expected,
                                 input core_pkg::wb_trace_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("error %s expected pc=%h r%0d=%h actual pc=%h r%0d=%h", name,
                     expected.pc, expected.rd, expected.data,
                     actual.pc, actual.rd, actual.data);
        end
    endtask

    task automatic compare_word(input string name, input core_pkg::data_t expected,
                                input core_pkg::data_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("error %s expected %h actual %h", name, expected, actual);
        end
    endtask

    always @(posedge clock) begin
        if (!reset && !first_seen) begin
            first_seen = 1'b1;
            compare_word("first fetch address", reset_pc, iram_req.addr);
            if (!iram_req.rd_en) begin
                other_errors++;
                $display("no instruction read in the first cycle after reset");
            end
        end
        if (!reset && iram_req.wr_en) begin
            other_errors++;
            $display("write request on the instruction memory at %h", iram_req.addr);
        end
        if (!reset && retired == 0 && !trace.wr_en && (dram_req.rd_en || dram_req.wr_en)) begin
            other_errors++;
            $display("data memory request before the first instruction retired");
        end
        if (!reset && trace.wr_en) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("register write at pc %h with none expected", trace.pc);
            end else begin
                compare_trace("trace", exp_q.pop_front(), trace);
            end
            retired++;
        end
    end

    initial begin
        #1;
        repeat (prog_len * 3 + 200 + 4) @(posedge clock);
        $display("timeout with %0d of %0d register writes retired", retired, n_expected);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        reset = 1'b1;
        iram_rd_data = '0;
        dram_rd_data = '0;
        lfsr = 32'hdee1;
        build_program();
        foreach (dmem[i]) begin
            dmem[i] = take_bits(32);
            ref_dmem[i] = dmem[i];
        end
        run_reference();
        n_expected = exp_q.size();
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        wait (retired >= n_expected);
        @(posedge clock);
        foreach (dmem[i]) begin
            compare_word($sformatf("dmem[%0d]", i), ref_dmem[i], dmem[i]);
        end
        $display("%0d writes checked, %0d value errors, %0d other errors",
                 retired, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== verif/core_tb_props.sv ====
`timescale 1ns/100ps

module core_tb_props (
    input logic                clock,
    input logic                reset,
    input core_pkg::sram_req_t iram_req,
    input core_pkg::sram_req_t dram_req,
    input core_pkg::wb_trace_t trace
);

    no_r0_trace: assert property (@(posedge clock) disable iff (reset)
        trace.wr_en |-> trace.rd != '0)
        else $error("trace shows a write to r0");

    dram_rd_wr_excl: assert property (@(posedge clock) disable iff (reset)
        !(dram_req.rd_en && dram_req.wr_en))
        else $error("dram read and write high together");

    // first reset cycle may still carry power-up state
    quiet_in_reset: assert property (@(posedge clock)
        reset && $past(reset) |-> !iram_req.rd_en && !dram_req.rd_en && !dram_req.wr_en)
        else $error("memory request during reset");

endmodule

bind core core_tb_props props_i (
    .clock(clock),
    .reset(reset),
    .iram_req(iram_req),
    .dram_req(dram_req),
    .trace(trace)
);

// ==== verilog/core.sv ====
`timescale 1ns/100ps

module core #(
    parameter core_pkg::addr_t reset_pc = 32'h1c00_0000
) (
    input  logic                clock,
    input  logic                reset,
    output core_pkg::sram_req_t iram_req,
    input  core_pkg::data_t     iram_rd_data,
    output core_pkg::sram_req_t dram_req,
    input  core_pkg::data_t     dram_rd_data,
    output core_pkg::wb_trace_t trace
);

    core_pkg::addr_t     if_pc;
    core_pkg::data_t     if_inst;
    logic                inst_valid;
    logic                fetch_stall;
    logic                ex_bubble;
    logic                redirect;
    core_pkg::addr_t     redirect_pc;
    logic                branch_taken;
    core_pkg::addr_t     branch_target;
    core_pkg::reg_addr_t rs_a;
    core_pkg::reg_addr_t rs_b;
    core_pkg::data_t     op_a;
    core_pkg::data_t     op_b;
    logic                hazard_a;
    logic                hazard_b;
    core_pkg::reg_addr_t rf_addr_a;
    core_pkg::reg_addr_t rf_addr_b;
    core_pkg::data_t     rf_data_a;
    core_pkg::data_t     rf_data_b;
    core_pkg::id_ex_t    id_ex_d;
    core_pkg::id_ex_t    id_ex_q;
    logic                ex_valid;
    core_pkg::ex_mem_t   ex_mem_d;
    core_pkg::ex_mem_t   ex_mem_q;
    logic                mem_valid;
    core_pkg::mem_wb_t   mem_wb_d;
    core_pkg::mem_wb_t   mem_wb_q;
    logic                wb_valid;
    core_pkg::fwd_src_t  ex_fwd;
    core_pkg::fwd_src_t  mem_fwd;
    core_pkg::fwd_src_t  wb_fwd;
    logic                rf_wr_en;
    core_pkg::reg_addr_t rf_wr_addr;
    core_pkg::data_t     rf_wr_data;

    pipeline_control ctrl_i (
        .clock(clock), .reset(reset),
        .inst_valid(inst_valid), .hazard_a(hazard_a), .hazard_b(hazard_b),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .fetch_stall(fetch_stall), .decode_stall(), .ex_bubble(ex_bubble),
        .redirect(redirect), .redirect_pc(redirect_pc)
    );

    inst_fetch #(.reset_pc(reset_pc)) fetch_i (
        .clock(clock), .reset(reset),
        .fetch_stall(fetch_stall), .redirect(redirect), .redirect_pc(redirect_pc),
        .iram_req(iram_req), .iram_rd_data(iram_rd_data),
        .pc(if_pc), .inst(if_inst), .inst_valid(inst_valid)
    );

    inst_decode decode_i (
        .pc(if_pc), .inst(if_inst), .inst_valid(inst_valid),
        .rs_a(rs_a), .rs_b(rs_b), .op_a(op_a), .op_b(op_b),
        .id_ex(id_ex_d), .branch_taken(branch_taken), .branch_target(branch_target)
    );

    reg_file_bypass bypass_a_i (
        .rs(rs_a), .ex_src(ex_fwd), .mem_src(mem_fwd), .wb_src(wb_fwd),
        .rf_addr(rf_addr_a), .rf_data(rf_data_a), .value(op_a), .hazard(hazard_a)
    );

    reg_file_bypass bypass_b_i (
        .rs(rs_b), .ex_src(ex_fwd), .mem_src(mem_fwd), .wb_src(wb_fwd),
        .rf_addr(rf_addr_b), .rf_data(rf_data_b), .value(op_b), .hazard(hazard_b)
    );

    reg_file rf_i (
        .clock(clock), .reset(reset),
        .rd_addr_a(rf_addr_a), .rd_data_a(rf_data_a),
        .rd_addr_b(rf_addr_b), .rd_data_b(rf_data_b),
        .wr_en(rf_wr_en), .wr_addr(rf_wr_addr), .wr_data(rf_wr_data)
    );

    stage_reg #(.payload_t(core_pkg::id_ex_t)) id_ex_i (
        .clock(clock), .reset(reset), .stall(1'b0), .flush(ex_bubble),
        .valid_in(inst_valid), .data_in(id_ex_d), .valid(ex_valid), .data(id_ex_q)
    );

    execute execute_i (
        .id_ex(id_ex_q), .valid(ex_valid), .ex_mem(ex_mem_d), .fwd(ex_fwd)
    );

    stage_reg #(.payload_t(core_pkg::ex_mem_t)) ex_mem_i (
        .clock(clock), .reset(reset), .stall(1'b0), .flush(1'b0),
        .valid_in(ex_valid), .data_in(ex_mem_d), .valid(mem_valid), .data(ex_mem_q)
    );

    mem_writeback mem_wb_unit_i (
        .mem(ex_mem_q), .mem_valid(mem_valid), .dram_req(dram_req),
        .mem_wb(mem_wb_d), .mem_fwd(mem_fwd),
        .wb(mem_wb_q), .wb_valid(wb_valid), .dram_rd_data(dram_rd_data), .wb_fwd(wb_fwd),
        .rf_wr_en(rf_wr_en), .rf_wr_addr(rf_wr_addr), .rf_wr_data(rf_wr_data),
        .trace(trace)
    );

    stage_reg #(.payload_t(core_pkg::mem_wb_t)) mem_wb_i (
        .clock(clock), .reset(reset), .stall(1'b0), .flush(1'b0),
        .valid_in(mem_valid), .data_in(mem_wb_d), .valid(wb_valid), .data(mem_wb_q)
    );

endmodule

// ==== verilog/core_pkg.sv ====
package core_pkg;

    typedef logic [31:0] data_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0] reg_addr_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b
    } alu_op_t;

    // three-register ops, inst[31:15]
    typedef enum logic [16:0] {
        op_add_w = 17'h00020,
        op_sub_w = 17'h00022,
        op_and   = 17'h00029,
        op_or    = 17'h0002a,
        op_xor   = 17'h0002b
    } op_3r_t;

    // 12-bit immediate ops, inst[31:22]
    typedef enum logic [9:0] {
        op_addi_w = 10'h00a,
        op_ld_w   = 10'h0a2,
        op_st_w   = 10'h0a6
    } op_2ri12_t;

    // inst[31:25]
    typedef enum logic [6:0] {
        op_lu12i_w = 7'h0a
    } op_1ri20_t;

    // inst[31:26]
    typedef enum logic [5:0] {
        op_b   = 6'h14,
        op_beq = 6'h16,
        op_bne = 6'h17
    } op_br_t;

    typedef struct packed {
        logic       rd_en;
        logic       wr_en;
        addr_t      addr;
        data_t      wr_data;
        logic [3:0] wr_mask;
    } sram_req_t;

    typedef struct packed {
        addr_t     pc;
        alu_op_t   alu_op;
        data_t     op_a;
        data_t     op_b;
        data_t     st_data;
        reg_addr_t rd;
        logic      wr_en;
        logic      is_load;
        logic      is_store;
    } id_ex_t;

    typedef struct packed {
        addr_t     pc;
        data_t     result;
        data_t     st_data;
        reg_addr_t rd;
        logic      wr_en;
        logic      is_load;
        logic      is_store;
    } ex_mem_t;

    typedef struct packed {
        addr_t     pc;
        data_t     result;
        reg_addr_t rd;
        logic      wr_en;
        logic      is_load;
    } mem_wb_t;

    typedef struct packed {
        addr_t     pc;
        reg_addr_t rd;
        data_t     data;
        logic      wr_en;
    } wb_trace_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        logic      wr_en;
        data_t     value;
        logic      is_load;
    } fwd_src_t;

endpackage

// ==== verilog/execute.sv ====
`timescale 1ns/100ps

module execute (
    input  core_pkg::id_ex_t   id_ex,
    input  logic               valid,
    output core_pkg::ex_mem_t  ex_mem,
    output core_pkg::fwd_src_t fwd
);

    core_pkg::data_t sum;
    core_pkg::data_t result;

    // also the ld.w and st.w address
    assign sum = id_ex.op_a + id_ex.op_b;

    always_comb begin
        case (id_ex.alu_op)
            core_pkg::alu_sub:    result = id_ex.op_a - id_ex.op_b;
            core_pkg::alu_and:    result = id_ex.op_a & id_ex.op_b;
            core_pkg::alu_or:     result = id_ex.op_a | id_ex.op_b;
            core_pkg::alu_xor:    result = id_ex.op_a ^ id_ex.op_b;
            core_pkg::alu_pass_b: result = id_ex.op_b;
            default:              result = sum;
        endcase
    end

    assign ex_mem = '{
        pc:       id_ex.pc,
        result:   result,
        st_data:  id_ex.st_data,
        rd:       id_ex.rd,
        wr_en:    id_ex.wr_en,
        is_load:  id_ex.is_load,
        is_store: id_ex.is_store
    };

    // a load here only carries its address, the bypass turns it into a hazard
    assign fwd = '{valid: valid, rd: id_ex.rd, wr_en: id_ex.wr_en, value: result,
                   is_load: id_ex.is_load};

endmodule

// ==== verilog/inst_decode.sv ====
`timescale 1ns/100ps

module inst_decode (
    input  core_pkg::addr_t     pc,
    input  core_pkg::data_t     inst,
    input  logic                inst_valid,
    output core_pkg::reg_addr_t rs_a,
    output core_pkg::reg_addr_t rs_b,
    input  core_pkg::data_t     op_a,
    input  core_pkg::data_t     op_b,
    output core_pkg::id_ex_t    id_ex,
    output logic                branch_taken,
    output core_pkg::addr_t     branch_target
);

    core_pkg::reg_addr_t rd;
    core_pkg::reg_addr_t rj;
    core_pkg::reg_addr_t rk;
    core_pkg::data_t     si12;
    core_pkg::data_t     lu_imm;
    core_pkg::data_t     offs16;
    core_pkg::data_t     offs26;
    core_pkg::data_t     imm_b;
    core_pkg::alu_op_t   alu_op;
    logic is_3r;
    logic is_addi;
    logic is_lu12i;
    logic is_ld;
    logic is_st;
    logic is_beq;
    logic is_bne;
    logic is_b;

    assign rd = inst[4:0];
    assign rj = inst[9:5];
    assign rk = inst[14:10];

    assign si12 = {{20{inst[21]}}, inst[21:10]};
    assign lu_imm = {inst[24:5], 12'b0};
    assign offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    assign offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    assign is_3r = inst[31:15] inside {core_pkg::op_add_w, core_pkg::op_sub_w,
                                       core_pkg::op_and, core_pkg::op_or, core_pkg::op_xor};
    assign is_addi = inst[31:22] == core_pkg::op_addi_w;
    assign is_ld = inst[31:22] == core_pkg::op_ld_w;
    assign is_st = inst[31:22] == core_pkg::op_st_w;
    assign is_lu12i = inst[31:25] == core_pkg::op_lu12i_w;
    assign is_beq = inst[31:26] == core_pkg::op_beq;
    assign is_bne = inst[31:26] == core_pkg::op_bne;
    assign is_b = inst[31:26] == core_pkg::op_b;

    // unused source fields read as r0 so they never raise a hazard
    assign rs_a = (is_lu12i || is_b) ? '0 : rj;
    assign rs_b = (is_beq || is_bne || is_st) ? rd : (is_3r ? rk : '0);

    always_comb begin
        case (inst[31:15])
            core_pkg::op_sub_w: alu_op = core_pkg::alu_sub;
            core_pkg::op_and:   alu_op = core_pkg::alu_and;
            core_pkg::op_or:    alu_op = core_pkg::alu_or;
            core_pkg::op_xor:   alu_op = core_pkg::alu_xor;
            default:            alu_op = is_lu12i ? core_pkg::alu_pass_b : core_pkg::alu_add;
        endcase
    end

    assign imm_b = is_lu12i ? lu_imm : si12;

    assign id_ex = '{
        pc:       pc,
        alu_op:   alu_op,
        op_a:     op_a,
        op_b:     is_3r ? op_b : imm_b,
        st_data:  op_b,
        rd:       rd,
        wr_en:    inst_valid & (is_3r | is_addi | is_lu12i | is_ld),
        is_load:  inst_valid & is_ld,
        is_store: inst_valid & is_st
    };

    // beq and bne compare rj against rd
    assign branch_taken = inst_valid & (is_b | (is_beq & (op_a == op_b))
                                             | (is_bne & (op_a != op_b)));
    assign branch_target = pc + (is_b ? offs26 : offs16);

endmodule

// ==== verilog/inst_fetch.sv ====
`timescale 1ns/100ps

module inst_fetch #(
    parameter core_pkg::addr_t reset_pc = 32'h1c00_0000
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                fetch_stall,
    input  logic                redirect,
    input  core_pkg::addr_t     redirect_pc,
    output core_pkg::sram_req_t iram_req,
    input  core_pkg::data_t     iram_rd_data,
    output core_pkg::addr_t     pc,
    output core_pkg::data_t     inst,
    output logic                inst_valid
);

    core_pkg::addr_t fetch_pc;
    core_pkg::addr_t req_pc;
    core_pkg::data_t hold_inst;
    logic            req_en;
    logic            rsp_valid;
    logic            hold_valid;

    assign req_en = ~reset & ~fetch_stall;
    assign iram_req = '{rd_en: req_en, wr_en: 1'b0, addr: fetch_pc, wr_data: '0, wr_mask: '0};

    // decode sees the held word until the stall releases
    assign pc = req_pc;
    assign inst = hold_valid ? hold_inst : iram_rd_data;
    assign inst_valid = hold_valid | rsp_valid;

    always_ff @(posedge clock) begin
        if (reset) begin
            fetch_pc <= reset_pc;
            rsp_valid <= 1'b0;
            hold_valid <= 1'b0;
        end else begin
            rsp_valid <= req_en;
            if (redirect) begin
                fetch_pc <= redirect_pc;
            end else if (!fetch_stall) begin
                fetch_pc <= fetch_pc + 32'd4;
            end
            if (!fetch_stall) begin
                hold_valid <= 1'b0;
            end else if (rsp_valid) begin
                hold_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (req_en) begin
            req_pc <= fetch_pc;
        end
        if (fetch_stall && rsp_valid) begin
            hold_inst <= iram_rd_data;
        end
    end

endmodule

// ==== verilog/mem_writeback.sv ====
`timescale 1ns/100ps

module mem_writeback (
    input  core_pkg::ex_mem_t   mem,
    input  logic                mem_valid,
    output core_pkg::sram_req_t dram_req,
    output core_pkg::mem_wb_t   mem_wb,
    output core_pkg::fwd_src_t  mem_fwd,
    input  core_pkg::mem_wb_t   wb,
    input  logic                wb_valid,
    input  core_pkg::data_t     dram_rd_data,
    output core_pkg::fwd_src_t  wb_fwd,
    output logic                rf_wr_en,
    output core_pkg::reg_addr_t rf_wr_addr,
    output core_pkg::data_t     rf_wr_data,
    output core_pkg::wb_trace_t trace
);

    core_pkg::data_t wb_data;
    logic            wb_write;

    // word access only
    assign dram_req = '{rd_en: mem_valid & mem.is_load, wr_en: mem_valid & mem.is_store,
                        addr: mem.result, wr_data: mem.st_data, wr_mask: 4'hf};

    assign mem_wb = '{pc: mem.pc, result: mem.result, rd: mem.rd, wr_en: mem.wr_en,
                      is_load: mem.is_load};
    assign mem_fwd = '{valid: mem_valid, rd: mem.rd, wr_en: mem.wr_en, value: mem.result,
                       is_load: mem.is_load};

    // dram answers in this cycle for a load issued last cycle
    assign wb_data = wb.is_load ? dram_rd_data : wb.result;
    assign wb_write = wb_valid & wb.wr_en & (wb.rd != '0);

    assign wb_fwd = '{valid: wb_valid, rd: wb.rd, wr_en: wb.wr_en, value: wb_data,
                      is_load: wb.is_load};

    assign rf_wr_en = wb_write;
    assign rf_wr_addr = wb.rd;
    assign rf_wr_data = wb_data;

    assign trace = '{pc: wb.pc, rd: wb.rd, data: wb_data, wr_en: wb_write};

endmodule

// ==== verilog/pipeline_control.sv ====
`timescale 1ns/100ps

module pipeline_control (
    input  logic            clock,
    input  logic            reset,
    input  logic            inst_valid,
    input  logic            hazard_a,
    input  logic            hazard_b,
    input  logic            branch_taken,
    input  core_pkg::addr_t branch_target,
    output logic            fetch_stall,
    output logic            decode_stall,
    output logic            ex_bubble,
    output logic            redirect,
    output core_pkg::addr_t redirect_pc
);

    logic hazard;
    // set for the cycle after a redirect, wrong-path instruction in decode
    logic branch_shadow;

    assign hazard = hazard_a | hazard_b;

    // nothing issues from decode without a live instruction and clean operands
    assign decode_stall = ~inst_valid | branch_shadow | hazard;

    // only a real hazard holds fetch, otherwise it keeps filling decode
    assign fetch_stall = inst_valid & ~branch_shadow & hazard;

    assign ex_bubble = decode_stall;

    assign redirect = branch_taken & ~decode_stall;
    assign redirect_pc = branch_target;

    always_ff @(posedge clock) begin
        if (reset) begin
            branch_shadow <= 1'b0;
        end else begin
            branch_shadow <= redirect;
        end
    end

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
    input  logic                clock,
    input  logic                reset,
    input  core_pkg::reg_addr_t rd_addr_a,
    output core_pkg::data_t     rd_data_a,
    input  core_pkg::reg_addr_t rd_addr_b,
    output core_pkg::data_t     rd_data_b,
    input  logic                wr_en,
    input  core_pkg::reg_addr_t wr_addr,
    input  core_pkg::data_t     wr_data
);

    core_pkg::data_t regs [32];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

endmodule

// ==== verilog/reg_file_bypass.sv ====
`timescale 1ns/100ps

module reg_file_bypass (
    input  core_pkg::reg_addr_t rs,
    input  core_pkg::fwd_src_t  ex_src,
    input  core_pkg::fwd_src_t  mem_src,
    input  core_pkg::fwd_src_t  wb_src,
    output core_pkg::reg_addr_t rf_addr,
    input  core_pkg::data_t     rf_data,
    output core_pkg::data_t     value,
    output logic                hazard
);

    logic ex_hit;
    logic mem_hit;
    logic wb_hit;

    assign rf_addr = rs;

    // r0 never matches, its value comes from the register file as zero
    assign ex_hit = ex_src.valid & ex_src.wr_en & (ex_src.rd == rs) & (rs != '0);
    assign mem_hit = mem_src.valid & mem_src.wr_en & (mem_src.rd == rs) & (rs != '0);
    assign wb_hit = wb_src.valid & wb_src.wr_en & (wb_src.rd == rs) & (rs != '0);

    always_comb begin
        hazard = 1'b0;
        value = rf_data;
        if (ex_hit) begin
            value = ex_src.value;
            hazard = ex_src.is_load;
        end else if (mem_hit) begin
            value = mem_src.value;
            hazard = mem_src.is_load;
        end else if (wb_hit) begin
            // load data is already selected in writeback
            value = wb_src.value;
        end
    end

endmodule

// ==== verilog/stage_reg.sv ====
`timescale 1ns/100ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     stall,
    input  logic     flush,
    input  logic     valid_in,
    input  payload_t data_in,
    output logic     valid,
    output payload_t data
);

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            valid <= 1'b0;
        end else if (!stall) begin
            valid <= valid_in;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            data <= data_in;
        end
    end

endmodule
